/* execute_settings.svh */
`ifndef EXECUTE_SETTINGS_SVH
`define EXECUTE_SETTINGS_SVH

// Datapath word width
`define DATA_WIDTH 32

// Register number width, sixteen architectural registers
`define REG_ADDR_WIDTH 4

// NZCV value after reset
`define FLAGS_RESET 4'b0000

`endif

/* execute_pkg.sv */
`include "execute_settings.svh"

package execute_pkg;

	typedef logic [`DATA_WIDTH-1:0] word_t;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;

	// N is bit 3, V is bit 0
	typedef logic [3:0] flags_t;

	// 0 register file, 1 writeback, 2 memory stage, 3 same as 0
	typedef logic [1:0] fwdSel_t;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_ORR = 4'd3,
		ALU_EOR = 4'd4,
		ALU_MOV = 4'd5,
		ALU_MUL = 4'd6,
		ALU_MLA = 4'd7
	} aluOp_t;

	typedef enum logic [3:0] {
		COND_EQ  = 4'd0,
		COND_NE  = 4'd1,
		COND_CS  = 4'd2,
		COND_CC  = 4'd3,
		COND_MI  = 4'd4,
		COND_PL  = 4'd5,
		COND_VS  = 4'd6,
		COND_VC  = 4'd7,
		COND_HI  = 4'd8,
		COND_LS  = 4'd9,
		COND_GE  = 4'd10,
		COND_LT  = 4'd11,
		COND_GT  = 4'd12,
		COND_LE  = 4'd13,
		COND_AL  = 4'd14,
		COND_UNC = 4'd15
	} cond_t;

endpackage

/* operandForward.sv */
`timescale 1ns/1ps

module operandForward import execute_pkg::*; (
	input  fwdSel_t forwardAE,
	input  fwdSel_t forwardBE,
	input  logic    aluSrcE,
	input  word_t   rdA,
	input  word_t   rdB,
	input  word_t   extImm,
	input  word_t   resultW,
	input  word_t   aluResultM,
	output word_t   srcA,
	output word_t   srcB,
	output word_t   writeData
);

	// Shared three-way selector for both operands
	function automatic word_t fwdMux(
		input fwdSel_t sel,
		input word_t   regVal,
		input word_t   wbVal,
		input word_t   memVal
	);
		word_t picked;
		case (sel)
			2'd1:    picked = wbVal;
			2'd2:    picked = memVal;
			default: picked = regVal;
		endcase
		return picked;
	endfunction

	word_t fwdB;

	assign srcA = fwdMux(forwardAE, rdA, resultW, aluResultM);
	assign fwdB = fwdMux(forwardBE, rdB, resultW, aluResultM);

	// Store data is taken before the immediate choice
	assign writeData = fwdB;
	assign srcB      = aluSrcE ? extImm : fwdB;

endmodule

/* alu.sv */
`timescale 1ns/1ps
`include "execute_settings.svh"

module alu import execute_pkg::*; (
	input  word_t  srcA,
	input  word_t  srcB,
	input  word_t  rdC,
	input  aluOp_t aluControl,
	output word_t  result,
	output flags_t aluFlags
);

	logic                 isSub;
	logic                 isArith;
	word_t                bOperand;
	logic [`DATA_WIDTH:0] sum;
	word_t                product;
	logic                 carry;
	logic                 overflow;

	assign isSub   = (aluControl == ALU_SUB);
	assign isArith = (aluControl == ALU_ADD) || isSub;

	// SUB is A + ~B + 1, so carry out means no borrow
	assign bOperand = isSub ? ~srcB : srcB;
	assign sum = {1'b0, srcA} + {1'b0, bOperand} + {{`DATA_WIDTH{1'b0}}, isSub};

	// Low word of the product only
	assign product = srcA * srcB;

	assign carry = sum[`DATA_WIDTH];

	// Same-sign inputs giving a different-sign sum
	assign overflow = (srcA[`DATA_WIDTH-1] == bOperand[`DATA_WIDTH-1]) &&
		(sum[`DATA_WIDTH-1] != srcA[`DATA_WIDTH-1]);

	always_comb begin
		case (aluControl)
			ALU_ADD: result = sum[`DATA_WIDTH-1:0];
			ALU_SUB: result = sum[`DATA_WIDTH-1:0];
			ALU_AND: result = srcA & srcB;
			ALU_ORR: result = srcA | srcB;
			ALU_EOR: result = srcA ^ srcB;
			ALU_MOV: result = srcB;
			ALU_MUL: result = product;
			ALU_MLA: result = product + rdC;
			// Unused opcodes
			default: result = '0;
		endcase
	end

	always_comb begin
		aluFlags[3] = result[`DATA_WIDTH-1];
		aluFlags[2] = (result == '0);
		aluFlags[1] = isArith ? carry : 1'b0;
		aluFlags[0] = isArith ? overflow : 1'b0;
	end

endmodule

/* condUnit.sv */
`timescale 1ns/1ps
`include "execute_settings.svh"

module condUnit import execute_pkg::*; (
	input  logic   Clk,
	input  logic   rstN,
	input  cond_t  condE,
	input  logic   flagWriteE,
	input  flags_t aluFlags,
	output logic   condEx,
	output flags_t flags
);

	logic n;
	logic z;
	logic c;
	logic v;

	// Condition is judged on the stored flags, not this cycle's ALU flags
	assign n = flags[3];
	assign z = flags[2];
	assign c = flags[1];
	assign v = flags[0];

	always_comb begin
		case (condE)
			COND_EQ:  condEx = z;
			COND_NE:  condEx = ~z;
			COND_CS:  condEx = c;
			COND_CC:  condEx = ~c;
			COND_MI:  condEx = n;
			COND_PL:  condEx = ~n;
			COND_VS:  condEx = v;
			COND_VC:  condEx = ~v;
			COND_HI:  condEx = c & ~z;
			COND_LS:  condEx = ~c | z;
			COND_GE:  condEx = (n == v);
			COND_LT:  condEx = (n != v);
			COND_GT:  condEx = ~z & (n == v);
			COND_LE:  condEx = z | (n != v);
			COND_AL:  condEx = 1'b1;
			COND_UNC: condEx = 1'b1;
			default:  condEx = 1'b1;
		endcase
	end

	// Only an instruction that actually executes may set flags
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			flags <= `FLAGS_RESET;
		end else if (flagWriteE && condEx) begin
			flags <= aluFlags;
		end
	end

endmodule

/* pipeExeMem.sv */
`timescale 1ns/1ps

module pipeExeMem import execute_pkg::*; (
	input  logic     Clk,
	input  logic     rstN,
	input  logic     regWriteIn,
	input  logic     pcSrcIn,
	input  logic     memToRegIn,
	input  logic     memWriteIn,
	input  word_t    aluResultIn,
	input  word_t    writeDataIn,
	input  regAddr_t wa3In,
	output logic     regWriteM,
	output logic     pcSrcM,
	output logic     memToRegM,
	output logic     memWriteM,
	output word_t    aluResultM,
	output word_t    writeDataM,
	output regAddr_t wa3M
);

	// Control bits, cleared so no bogus write leaves the stage
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			regWriteM <= 1'b0;
			pcSrcM    <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
		end else begin
			regWriteM <= regWriteIn;
			pcSrcM    <= pcSrcIn;
			memToRegM <= memToRegIn;
			memWriteM <= memWriteIn;
		end
	end

	// Payload
	always_ff @(posedge Clk) begin
		aluResultM <= aluResultIn;
		writeDataM <= writeDataIn;
		wa3M       <= wa3In;
	end

endmodule

/* execute.sv */
`timescale 1ns/1ps

module execute import execute_pkg::*; (
	input  logic     Clk,
	input  logic     rstN,
	input  logic     regWriteE,
	input  logic     pcSrcE,
	input  logic     branchE,
	input  logic     aluSrcE,
	input  logic     memToRegE,
	input  logic     flagWriteE,
	input  logic     memWriteE,
	input  fwdSel_t  forwardAE,
	input  fwdSel_t  forwardBE,
	input  word_t    rdA,
	input  word_t    rdB,
	input  word_t    rdC,
	input  word_t    extImm,
	input  word_t    resultW,
	input  regAddr_t wa3E,
	input  aluOp_t   aluControlE,
	input  cond_t    condE,
	output word_t    aluResultE,
	output word_t    aluResultM,
	output word_t    writeDataM,
	output regAddr_t wa3M,
	output flags_t   flags,
	output logic     branchTakenE,
	output logic     regWriteM,
	output logic     pcSrcM,
	output logic     memToRegM,
	output logic     memWriteM
);

	word_t  srcA;
	word_t  srcB;
	word_t  writeData;
	word_t  aluResult;
	flags_t aluFlags;
	logic   condEx;
	logic   regWriteGated;
	logic   pcSrcGated;
	logic   memWriteGated;

	// Memory-stage forward comes from our own EX/MEM register
	operandForward u_operandForward (
		.forwardAE  (forwardAE),
		.forwardBE  (forwardBE),
		.aluSrcE    (aluSrcE),
		.rdA        (rdA),
		.rdB        (rdB),
		.extImm     (extImm),
		.resultW    (resultW),
		.aluResultM (aluResultM),
		.srcA       (srcA),
		.srcB       (srcB),
		.writeData  (writeData)
	);

	alu u_alu (
		.srcA       (srcA),
		.srcB       (srcB),
		.rdC        (rdC),
		.aluControl (aluControlE),
		.result     (aluResult),
		.aluFlags   (aluFlags)
	);

	condUnit u_condUnit (
		.Clk        (Clk),
		.rstN       (rstN),
		.condE      (condE),
		.flagWriteE (flagWriteE),
		.aluFlags   (aluFlags),
		.condEx     (condEx),
		.flags      (flags)
	);

	// Side effects only happen when the condition passes
	assign regWriteGated = regWriteE & condEx;
	assign pcSrcGated    = pcSrcE & condEx;
	assign memWriteGated = memWriteE & condEx;
	assign branchTakenE  = branchE & condEx;

	assign aluResultE = aluResult;

	pipeExeMem u_pipeExeMem (
		.Clk         (Clk),
		.rstN        (rstN),
		.regWriteIn  (regWriteGated),
		.pcSrcIn     (pcSrcGated),
		.memToRegIn  (memToRegE),
		.memWriteIn  (memWriteGated),
		.aluResultIn (aluResult),
		.writeDataIn (writeData),
		.wa3In       (wa3E),
		.regWriteM   (regWriteM),
		.pcSrcM      (pcSrcM),
		.memToRegM   (memToRegM),
		.memWriteM   (memWriteM),
		.aluResultM  (aluResultM),
		.writeDataM  (writeDataM),
		.wa3M        (wa3M)
	);

endmodule

/* execute_checker.sv */
`timescale 1ns/1ps

module execute_checker import execute_pkg::*; (
	input logic  Clk,
	input logic  rstN,
	input logic  memWriteE,
	input logic  branchE,
	input cond_t condE,
	input logic  branchTakenE,
	input logic  regWriteM,
	input logic  pcSrcM,
	input logic  memToRegM,
	input logic  memWriteM
);

	int failCount = 0;

	// A reset edge leaves no control bit set on the memory side
	resetClearsControls: assert property (
		@(posedge Clk) !rstN |=> (!regWriteM && !pcSrcM && !memToRegM && !memWriteM)
	) else begin
		failCount++;
		$error("Control outputs were not cleared after a reset edge");
	end

	// A store can only leave the stage if one entered it the cycle before
	memWriteFromExecute: assert property (
		@(posedge Clk) memWriteM |-> $past(memWriteE)
	) else begin
		failCount++;
		$error("memWriteM is high but memWriteE was low one cycle earlier");
	end

	// A branch is taken only when requested, and always under AL
	branchNeedsBranch: assert property (
		@(posedge Clk) (!branchTakenE || branchE) &&
			(!(branchE && (condE inside {COND_AL, COND_UNC})) || branchTakenE)
	) else begin
		failCount++;
		$error("branchTakenE does not follow branchE");
	end

endmodule

/* execute_tb.sv */
`timescale 1ns/1ps
`include "execute_settings.svh"

module execute_tb import execute_pkg::*; ();

	localparam int RESET_CYCLES  = 10;
	localparam int ALU_CYCLES    = 64;
	localparam int FWD_CYCLES    = 32;
	localparam int FLAG_CYCLES   = 40;
	localparam int COND_CYCLES   = 96;
	localparam int STREAM_CYCLES = 200;
	localparam int TOTAL_CYCLES  = RESET_CYCLES + ALU_CYCLES + FWD_CYCLES + FLAG_CYCLES +
		COND_CYCLES + STREAM_CYCLES + 1;
	localparam int MARGIN        = 50;

	logic Clk;
	logic rstN;
	logic regWriteE, pcSrcE, branchE, aluSrcE, memToRegE, flagWriteE, memWriteE;
	fwdSel_t forwardAE, forwardBE;
	word_t rdA, rdB, rdC, extImm, resultW;
	regAddr_t wa3E;
	aluOp_t aluControlE;
	cond_t condE;
	word_t aluResultE, aluResultM, writeDataM;
	regAddr_t wa3M;
	flags_t flags;
	logic branchTakenE, regWriteM, pcSrcM, memToRegM, memWriteM;

	integer seed;
	logic [31:0] pick;
	int checks;
	int errors;

	// Model state: what the M outputs show now, and what they will show after the next edge
	logic curRegWrite, curPcSrc, curMemToReg, curMemWrite, curValid;
	logic nxtRegWrite, nxtPcSrc, nxtMemToReg, nxtMemWrite, nxtValid;
	word_t curAluResult, curWriteData, nxtAluResult, nxtWriteData;
	regAddr_t curWa3, nxtWa3;
	flags_t modelFlags, nxtFlags;

	execute u_execute (.*);

	bind execute execute_checker u_executeChecker (
		.Clk          (Clk),
		.rstN         (rstN),
		.memWriteE    (memWriteE),
		.branchE      (branchE),
		.condE        (condE),
		.branchTakenE (branchTakenE),
		.regWriteM    (regWriteM),
		.pcSrcM       (pcSrcM),
		.memToRegM    (memToRegM),
		.memWriteM    (memWriteM)
	);

	always #20 Clk = ~Clk;

	function automatic word_t pickOperand(input logic [1:0] sel, input word_t regVal,
		input word_t wbVal, input word_t memVal);
		if (sel == 2'd1)
			return wbVal;
		else if (sel == 2'd2)
			return memVal;
		return regVal;
	endfunction

	// Returns {N, Z, C, V, result}
	function automatic logic [35:0] refAlu(input logic [3:0] op, input word_t a,
		input word_t b, input word_t c);
		logic [32:0] wide;
		word_t res;
		logic cf;
		logic vf;
		cf = 1'b0;
		vf = 1'b0;
		res = '0;
		case (op)
			4'd0: begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[31:0];
				cf = wide[32];
				vf = (a[31] == b[31]) && (res[31] != a[31]);
			end
			4'd1: begin
				res = a - b;
				cf = (a >= b);
				vf = (a[31] != b[31]) && (res[31] != a[31]);
			end
			4'd2: res = a & b;
			4'd3: res = a | b;
			4'd4: res = a ^ b;
			4'd5: res = b;
			4'd6: res = a * b;
			4'd7: res = a * b + c;
			default: res = '0;
		endcase
		return {res[31], res == 32'd0, cf, vf, res};
	endfunction

	function automatic logic refCond(input logic [3:0] code, input flags_t f);
		logic n;
		logic z;
		logic c;
		logic v;
		n = f[3];
		z = f[2];
		c = f[1];
		v = f[0];
		case (code)
			4'd0:  return z;
			4'd1:  return !z;
			4'd2:  return c;
			4'd3:  return !c;
			4'd4:  return n;
			4'd5:  return !n;
			4'd6:  return v;
			4'd7:  return !v;
			4'd8:  return c && !z;
			4'd9:  return !c || z;
			4'd10: return n == v;
			4'd11: return n != v;
			4'd12: return !z && (n == v);
			4'd13: return z || (n != v);
			default: return 1'b1;
		endcase
	endfunction

	task automatic checkValue(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("FAIL %s %s: expected %h, actual %h", name, what, expected, actual);
		end
	endtask

	// Falling edge: registered outputs settled, safe to compare and drive
	task automatic waitEdge(input string name);
		@(negedge Clk);
		curRegWrite = nxtRegWrite;
		curPcSrc = nxtPcSrc;
		curMemToReg = nxtMemToReg;
		curMemWrite = nxtMemWrite;
		curAluResult = nxtAluResult;
		curWriteData = nxtWriteData;
		curWa3 = nxtWa3;
		curValid = nxtValid;
		modelFlags = nxtFlags;
		checkValue(name, "regWriteM", 32'(curRegWrite), 32'(regWriteM));
		checkValue(name, "pcSrcM", 32'(curPcSrc), 32'(pcSrcM));
		checkValue(name, "memToRegM", 32'(curMemToReg), 32'(memToRegM));
		checkValue(name, "memWriteM", 32'(curMemWrite), 32'(memWriteM));
		checkValue(name, "flags", 32'(modelFlags), 32'(flags));
		if (curValid) begin
			checkValue(name, "aluResultM", curAluResult, aluResultM);
			checkValue(name, "writeDataM", curWriteData, writeDataM);
			checkValue(name, "wa3M", 32'(curWa3), 32'(wa3M));
		end
	endtask

	task automatic evaluate(input string name);
		word_t a;
		word_t bFwd;
		word_t b;
		logic [35:0] refOut;
		logic cx;
		#1;
		a = pickOperand(forwardAE, rdA, resultW, curAluResult);
		bFwd = pickOperand(forwardBE, rdB, resultW, curAluResult);
		b = aluSrcE ? extImm : bFwd;
		refOut = refAlu(aluControlE, a, b, rdC);
		cx = refCond(condE, modelFlags);
		checkValue(name, "aluResultE", refOut[31:0], aluResultE);
		checkValue(name, "branchTakenE", 32'(branchE & cx), 32'(branchTakenE));
		nxtAluResult = refOut[31:0];
		nxtWriteData = bFwd;
		nxtWa3 = wa3E;
		nxtValid = 1'b1;
		if (!rstN) begin
			nxtRegWrite = 1'b0;
			nxtPcSrc = 1'b0;
			nxtMemToReg = 1'b0;
			nxtMemWrite = 1'b0;
			nxtFlags = `FLAGS_RESET;
		end else begin
			nxtRegWrite = regWriteE & cx;
			nxtPcSrc = pcSrcE & cx;
			nxtMemToReg = memToRegE;
			nxtMemWrite = memWriteE & cx;
			if (flagWriteE && cx)
				nxtFlags = refOut[35:32];
		end
	endtask

	task automatic randomInstr();
		logic [31:0] r;
		r = $random(seed);
		regWriteE = r[0];
		pcSrcE = r[1];
		aluControlE = aluOp_t'(r[11:8]);
		condE = cond_t'(r[15:12]);
		forwardAE = r[17:16];
		forwardBE = r[19:18];
		wa3E = r[23:20];
		aluSrcE = r[24];
		memToRegE = r[25];
		flagWriteE = r[26];
		memWriteE = r[27];
		branchE = r[28];
		rdA = $random(seed);
		rdB = $random(seed);
		rdC = $random(seed);
		extImm = $random(seed);
		resultW = $random(seed);
	endtask

	initial begin
		#((TOTAL_CYCLES + MARGIN) * 40);
		$display("Timeout: the run did not finish within %0d clock cycles", TOTAL_CYCLES + MARGIN);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		seed = 32'hacdd43c9;
		checks = 0;
		errors = 0;
		Clk = 1'b0;
		rstN = 1'b0;
		{regWriteE, pcSrcE, branchE, aluSrcE, memToRegE, flagWriteE, memWriteE} = '0;
		forwardAE = '0;
		forwardBE = '0;
		{rdA, rdB, rdC, extImm, resultW} = '0;
		wa3E = '0;
		aluControlE = ALU_ADD;
		condE = COND_AL;
		{nxtRegWrite, nxtPcSrc, nxtMemToReg, nxtMemWrite, nxtValid} = '0;
		{nxtAluResult, nxtWriteData, nxtWa3} = '0;
		nxtFlags = `FLAGS_RESET;

		for (int i = 0; i < RESET_CYCLES - 1; i++) begin
			waitEdge("reset");
			evaluate("reset");
		end
		waitEdge("reset");
		rstN = 1'b1;
		evaluate("reset");

		for (int op = 0; op < 16; op++) begin
			for (int rep = 0; rep < 4; rep++) begin
				waitEdge("alu");
				randomInstr();
				aluControlE = aluOp_t'(op[3:0]);
				forwardAE = 2'd0;
				forwardBE = 2'd0;
				aluSrcE = 1'b0;
				flagWriteE = 1'b0;
				evaluate("alu");
			end
		end

		for (int sel = 0; sel < FWD_CYCLES; sel++) begin
			waitEdge("forward");
			randomInstr();
			forwardAE = sel[1:0];
			forwardBE = sel[3:2];
			aluSrcE = sel[4];
			aluControlE = ALU_ADD;
			flagWriteE = 1'b0;
			evaluate("forward");
		end

		for (int i = 0; i < FLAG_CYCLES; i++) begin
			waitEdge("flags");
			randomInstr();
			pick = $random(seed);
			aluControlE = pick[0] ? ALU_SUB : ALU_ADD;
			forwardAE = 2'd0;
			forwardBE = 2'd0;
			aluSrcE = 1'b0;
			// Equal operands make zero results reachable
			if (pick[1])
				rdB = rdA;
			evaluate("flags");
		end

		for (int code = 0; code < 16; code++) begin
			for (int rep = 0; rep < 3; rep++) begin
				waitEdge("cond");
				randomInstr();
				pick = $random(seed);
				aluControlE = pick[0] ? ALU_SUB : ALU_ADD;
				forwardAE = 2'd0;
				forwardBE = 2'd0;
				aluSrcE = 1'b0;
				if (pick[1])
					rdB = rdA;
				flagWriteE = 1'b1;
				condE = COND_AL;
				evaluate("cond");
				waitEdge("cond");
				randomInstr();
				condE = cond_t'(code[3:0]);
				flagWriteE = 1'b0;
				{regWriteE, pcSrcE, memWriteE, branchE} = 4'hf;
				evaluate("cond");
			end
		end

		for (int i = 0; i < STREAM_CYCLES; i++) begin
			waitEdge("stream");
			randomInstr();
			evaluate("stream");
		end
		waitEdge("drain");

		$display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
			u_execute.u_executeChecker.failCount);
		if (errors == 0 && u_execute.u_executeChecker.failCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+.
execute_pkg.sv
operandForward.sv
alu.sv
condUnit.sv
pipeExeMem.sv
execute.sv
execute_checker.sv
execute_tb.sv

/* Makefile */
# Verilator flow for the execute stage testbench

VERILATOR  ?= verilator
TOP        ?= execute_tb
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Some tests failed
VFLAGS     ?=
LINT_FLAGS ?=
SIM_ARGS   ?= +verilator+error+limit+100

SOURCES := $(wildcard *.sv *.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
